// ==== Makefile ====
BIN  := obj_dir/decodeTb
SRCS := $(filter-out +incdir+%,$(shell cat flist.f)) src/cpu_defs.svh

.PHONY: all run clean

all: run

$(BIN): flist.f $(SRCS) sim/decode_input.txt
	verilator --binary --timing --assert -f flist.f --top-module decodeTb \
		-Mdir obj_dir -o decodeTb

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+src
src/cpuPkg.sv
src/cpuIfs.sv
src/instructionDecoder.sv
src/registerFile.sv
src/decodeStage.sv
src/decodeTop.sv
sim/decodeTb.sv

// ==== sim/decodeTb.sv ====
`include "cpu_defs.svh"

module decodeTb;

    typedef struct packed {
        logic [`ID_W-1:0]     id;
        logic [`REG_W-1:0]    regD;
        logic [`OFFSET_W-1:0] offset;
        logic [`COND_W-1:0]   cond;
        logic [`DATA_W-1:0]   dataA;
        logic [`DATA_W-1:0]   dataB;
        logic [31:0]          cycle;    // Cycle at which outValid is due
    } expBundle_t;

    logic                 clk;
    logic                 rstN;
    logic                 instrValid;
    logic [`INSTR_W-1:0]  instr;
    logic                 wrEn;
    logic [`REG_W-1:0]    wrAddr;
    logic [`DATA_W-1:0]   wrData;
    logic                 outValid;
    logic [`ID_W-1:0]     outId;
    logic [`REG_W-1:0]    outRegD;
    logic [`OFFSET_W-1:0] outOffset;
    logic [`COND_W-1:0]   outCond;
    logic [`DATA_W-1:0]   outDataA;
    logic [`DATA_W-1:0]   outDataB;

    logic [`DATA_W-1:0]   model [1 << `REG_W];    // Expected register contents
    expBundle_t           pending [$];            // Strobes still owed an output
    string                names [$];
    logic [31:0]          cycle = '0;
    logic                 holdWrite;              // Write to issue with the next strobe
    logic [`REG_W-1:0]    holdAddr;
    logic [`DATA_W-1:0]   holdData;
    int                   valueErrors = 0;
    int                   otherErrors = 0;

    decodeTop u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .outValid   (outValid),
        .outId      (outId),
        .outRegD    (outRegD),
        .outOffset  (outOffset),
        .outCond    (outCond),
        .outDataA   (outDataA),
        .outDataB   (outDataB)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 32'd1;

    task automatic checkId(input string name, input logic [`ID_W-1:0] exp,
                           input logic [`ID_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s id: expected %h, actual %h", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkReg(input string name, input logic [`REG_W-1:0] exp,
                            input logic [`REG_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s regD: expected %h, actual %h", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkOffset(input string name, input logic [`OFFSET_W-1:0] exp,
                               input logic [`OFFSET_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s offset: expected %h, actual %h", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkCond(input string name, input logic [`COND_W-1:0] exp,
                             input logic [`COND_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s cond: expected %h, actual %h", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkData(input string name, input string port,
                             input logic [`DATA_W-1:0] exp, input logic [`DATA_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", name, port, exp, act);
            valueErrors++;
        end
    endtask

    // Outputs sampled mid-cycle between drive and capture
    always @(negedge clk) begin
        expBundle_t want;
        string      who;
        if (rstN === 1'b1) begin
            if ($isunknown(outValid)) begin
                $display("outValid is unknown at cycle %0d", cycle);
                otherErrors++;
            end else if (outValid) begin
                if (pending.size() == 0) begin
                    $display("outValid high at cycle %0d with no strobe pending", cycle);
                    otherErrors++;
                end else begin
                    want = pending.pop_front();
                    who  = names.pop_front();
                    if (cycle != want.cycle) begin
                        $display("output for %s came at cycle %0d instead of cycle %0d",
                                 who, cycle, want.cycle);
                        otherErrors++;
                    end
                    checkId(who, want.id, outId);
                    checkReg(who, want.regD, outRegD);
                    checkOffset(who, want.offset, outOffset);
                    checkCond(who, want.cond, outCond);
                    checkData(who, "dataA", want.dataA, outDataA);
                    checkData(who, "dataB", want.dataB, outDataB);
                end
            end
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic writeReg(input logic [`REG_W-1:0] addr, input logic [`DATA_W-1:0] data);
        wrEn        = 1'b1;
        wrAddr      = addr;
        wrData      = data;
        model[addr] = data;
        stepCycle();
        wrEn = 1'b0;
    endtask

    task automatic strobeInstr(input string name, input logic [`INSTR_W-1:0] word,
                               input expBundle_t want);
        instr      = word;
        instrValid = 1'b1;
        if (holdWrite) begin
            wrEn            = 1'b1;
            wrAddr          = holdAddr;
            wrData          = holdData;
            model[holdAddr] = holdData;   // Lands on the same edge as the strobe
            holdWrite       = 1'b0;
        end
        pending.push_back(want);
        names.push_back(name);
        stepCycle();
        instrValid = 1'b0;
        wrEn       = 1'b0;
    endtask

    task automatic waitOutputs();
        int waited;
        waited = 0;
        do begin
            stepCycle();
            waited++;
        end while (pending.size() != 0 && waited < 10);
        while (pending.size() != 0) begin
            $display("no output for %s within timeout", names[0]);
            names.delete(0);
            pending.delete(0);
            otherErrors++;
        end
    endtask

    initial begin
        int                   fd;
        int                   code;
        string                kind;
        string                name;
        logic [8*128-1:0]     line;
        logic [`INSTR_W-1:0]  word;
        logic [`ID_W-1:0]     id;
        logic [`REG_W-1:0]    regD;
        logic [`OFFSET_W-1:0] offset;
        logic [`COND_W-1:0]   cond;
        logic [`REG_W-1:0]    idxA;
        logic [`REG_W-1:0]    idxB;
        logic                 burst;
        expBundle_t           want;

        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        wrEn       = 1'b0;
        wrAddr     = '0;
        wrData     = '0;
        holdWrite  = 1'b0;
        holdAddr   = '0;
        holdData   = '0;
        model      = '{default: '0};
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        repeat (3) stepCycle();               // Quiet cycles with outValid low

        // Distinct contents per index, R0 keeps its reset value
        for (int i = 1; i < (1 << `REG_W); i++) begin
            writeReg(i[3:0], {4'h5, i[3:0], 4'ha, ~i[3:0]});
        end

        fd = $fopen("sim/decode_input.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/decode_input.txt");
            otherErrors++;
        end
        while (fd != 0) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) break;
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "W") begin
                code = $fscanf(fd, "%h %h", holdAddr, holdData);
                writeReg(holdAddr, holdData);
            end else if (kind == "C") begin
                code      = $fscanf(fd, "%h %h", holdAddr, holdData);
                holdWrite = 1'b1;
            end else if (kind == "D") begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", name, word, id, regD,
                               offset, cond, idxA, idxB, burst);
                want.id     = id;
                want.regD   = regD;
                want.offset = offset;
                want.cond   = cond;
                want.dataA  = model[idxA];    // Contents before the strobe edge
                want.dataB  = model[idxB];
                want.cycle  = cycle + 32'd1;
                strobeInstr(name, word, want);
                if (!burst) waitOutputs();
            end else begin
                $display("unknown record kind %s in input file", kind);
                otherErrors++;
                code = $fgets(line, fd);
            end
        end
        if (fd != 0) $fclose(fd);
        if (pending.size() != 0) waitOutputs();

        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/decode_input.txt ====
# W idx value | C idx value, written in the cycle of the next D strobe
# D name instr id regD offset cond idxA idxB burst, idxA/idxB select the expected operands
W 1 1111
W 2 2222
W 3 3333
W 9 9999
W a aaaa
W e 0e0e
W f 0f0f
D addReg 188b 04 3 000 f 1 2 0
D lslImm 02d1 01 1 00b f 2 0 0
D ldrReg 5c53 2e 3 000 f 2 1 0
D aluReg 4253 15 3 000 f 3 2 0
D hiAdd 44d1 1e 9 000 f 9 a 0
D hiMov 468e 24 e 000 f e 1 0
D hiCmp 4551 1f 1 000 f 1 a 0
D movImm 2b5a 09 3 05a f 3 0 0
D addImm 32ff 0a 2 0ff f 2 0 0
D ldrSp 9910 37 1 010 f e 0 0
D addPc a244 38 2 044 f f 0 0
D pushm b496 4d 0 016 f e 0 0
D popm bd83 4e 0 003 f e 0 0
D bCond d320 49 0 020 3 f 0 0
D bl b105 4f c 000 e f 5 1
D bx b182 50 c 000 e f 2 0
D allOnes ffff 64 0 000 f 0 0 0
D hlt e800 4b 0 000 f 0 0 1
D nop e000 4a 0 000 f 0 0 1
D undefB b300 7a 0 000 f 0 0 0
C 1 beef
D sameCycle 188b 04 3 000 f 1 2 0
D afterWrite 188b 04 3 000 f 1 2 0

// ==== src/cpuIfs.sv ====
`include "cpu_defs.svh"

// Decoder fields toward the stage, purely combinational
interface decodeIf;
    logic [`ID_W-1:0]     id;
    logic [`REG_W-1:0]    regD;
    logic [`REG_W-1:0]    regA;
    logic [`REG_W-1:0]    regB;
    logic [`OFFSET_W-1:0] offset;
    logic [`COND_W-1:0]   branchCond;

    modport dec (output id, regD, regA, regB, offset, branchCond);
    modport stage (input id, regD, regA, regB, offset, branchCond);
endinterface

// Two same-cycle read ports of the register file
interface regReadIf;
    logic [`REG_W-1:0]  addrA;
    logic [`REG_W-1:0]  addrB;
    logic [`DATA_W-1:0] dataA;
    logic [`DATA_W-1:0] dataB;

    modport requester (output addrA, addrB, input dataA, dataB);
    modport file (input addrA, addrB, output dataA, dataB);
endinterface

// ==== src/cpuPkg.sv ====
package cpuPkg;

    // Same 16-bit word, register layout or immediate layout
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic       op;
            logic [1:0] funct1;
            logic [2:0] rB;
            logic [2:0] rA;
            logic [2:0] rD;
        } regFmt;
        struct packed {
            logic [3:0] opcode;
            logic       op;
            logic [2:0] rD;
            logic [7:0] imm8;
        } immFmt;
    } instrWord_t;

endpackage

// ==== src/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath widths
`define INSTR_W  16
`define ID_W     7
`define REG_W    4
`define OFFSET_W 12
`define COND_W   4
`define DATA_W   16

// Special register indices
`define LINK_REG 4'd12
`define SP_REG   4'd14
`define PC_REG   4'd15

`endif

// ==== src/decodeStage.sv ====
`include "cpu_defs.svh"

module decodeStage import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  instrWord_t           instr,
    regReadIf.requester          rd,
    output logic                 outValid,
    output logic [`ID_W-1:0]     outId,
    output logic [`REG_W-1:0]    outRegD,
    output logic [`OFFSET_W-1:0] outOffset,
    output logic [`COND_W-1:0]   outCond,
    output logic [`DATA_W-1:0]   outDataA,
    output logic [`DATA_W-1:0]   outDataB
);

    decodeIf decBus ();

    instructionDecoder u_dec (
        .instr (instr),
        .dec   (decBus.dec)
    );

    assign rd.addrA = decBus.regA;                      // Operand reads in the strobe cycle
    assign rd.addrB = decBus.regB;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= instrValid;                     // One pulse per strobe
        end
    end

    // Bundle holds its last value between strobes
    always_ff @(posedge clk) begin
        if (instrValid) begin
            outId     <= decBus.id;
            outRegD   <= decBus.regD;
            outOffset <= decBus.offset;
            outCond   <= decBus.branchCond;
            outDataA  <= rd.dataA;
            outDataB  <= rd.dataB;
        end
    end

    // Strobe must be clean once out of reset
    assert property (@(posedge clk) disable iff (!rstN) !$isunknown(instrValid));

    // Only branch forms carry a real condition
    assert property (@(posedge clk) disable iff (!rstN)
        instrValid && decBus.branchCond != 4'hf |->
            decBus.id inside {7'h26, 7'h49, 7'h4f, 7'h50});

endmodule

// ==== src/decodeTop.sv ====
`include "cpu_defs.svh"

module decodeTop (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  logic [`INSTR_W-1:0]  instr,
    input  logic                 wrEn,
    input  logic [`REG_W-1:0]    wrAddr,
    input  logic [`DATA_W-1:0]   wrData,
    output logic                 outValid,
    output logic [`ID_W-1:0]     outId,
    output logic [`REG_W-1:0]    outRegD,
    output logic [`OFFSET_W-1:0] outOffset,
    output logic [`COND_W-1:0]   outCond,
    output logic [`DATA_W-1:0]   outDataA,
    output logic [`DATA_W-1:0]   outDataB
);

    regReadIf rdBus ();

    decodeStage u_stage (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),                            // Raw word into the union port
        .rd         (rdBus.requester),
        .outValid   (outValid),
        .outId      (outId),
        .outRegD    (outRegD),
        .outOffset  (outOffset),
        .outCond    (outCond),
        .outDataA   (outDataA),
        .outDataB   (outDataB)
    );

    registerFile u_regs (
        .clk    (clk),
        .rstN   (rstN),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rd     (rdBus.file)
    );

endmodule

// ==== src/instructionDecoder.sv ====
`include "cpu_defs.svh"

module instructionDecoder import cpuPkg::*; (
    input  instrWord_t instr,
    decodeIf.dec       dec
);

    logic [3:0]           opcode;
    logic [4:0]           imm5;
    logic [7:0]           imm8;
    logic [3:0]           subB;      // Sub-opcode of formats D and B in bits 11:8
    logic [1:0]           fnB;       // Bits 7:6
    logic [`REG_W-1:0]    fldD;
    logic [`REG_W-1:0]    fldA;
    logic [`REG_W-1:0]    fldB;
    logic [`REG_W-1:0]    immD;
    logic [`ID_W-1:0]     id;
    logic [`REG_W-1:0]    regD;
    logic [`REG_W-1:0]    regA;
    logic [`REG_W-1:0]    regB;
    logic [`OFFSET_W-1:0] offset;
    logic [`COND_W-1:0]   cond;

    assign opcode = instr.regFmt.opcode;
    assign imm5   = {instr.regFmt.funct1, instr.regFmt.rB};
    assign imm8   = instr.immFmt.imm8;
    assign subB   = {instr.immFmt.op, instr.immFmt.rD};
    assign fnB    = imm8[7:6];
    assign fldD   = `REG_W'(instr.regFmt.rD);
    assign fldA   = `REG_W'(instr.regFmt.rA);
    assign fldB   = `REG_W'(instr.regFmt.rB);
    assign immD   = `REG_W'(instr.immFmt.rD);

    always_comb begin
        id     = '0;
        regD   = '0;
        regA   = '0;
        regB   = '0;
        offset = '0;
        cond   = 4'hf;                                      // Not a branch
        case (opcode)
            4'd0: begin                                     // Shift by immediate
                id     = instr.regFmt.op ? 7'h02 : 7'h01;
                regD   = fldD;
                regA   = fldA;
                offset = `OFFSET_W'(imm5);
            end
            4'd1: begin
                regD = fldD;
                regA = fldA;
                if (instr.regFmt.op) begin
                    case (instr.regFmt.funct1)
                        2'd0, 2'd1: begin                   // Add/sub register
                            id   = 7'h04 + {5'b0, instr.regFmt.funct1};
                            regB = fldB;
                        end
                        2'd2, 2'd3: begin                   // Add/sub 3-bit immediate
                            id     = 7'h04 + {5'b0, instr.regFmt.funct1};
                            offset = `OFFSET_W'(instr.regFmt.rB);
                        end
                        default: id = 7'h7e;
                    endcase
                end else begin
                    id     = 7'h03;
                    offset = `OFFSET_W'(imm5);
                end
            end
            4'd2, 4'd3: begin                               // Rd op imm8
                id     = 7'h08 + {5'b0, opcode[0], instr.immFmt.op};
                regD   = immD;
                regA   = immD;
                offset = `OFFSET_W'(imm8);
            end
            4'd4: begin
                if (instr.immFmt.op) begin                  // PC-relative load
                    id     = 7'h27;
                    regD   = immD;
                    regA   = `PC_REG;
                    regB   = immD;
                    offset = `OFFSET_W'(imm8);
                end else begin
                    regD = fldD;
                    regA = fldD;
                    regB = fldA;
                    case (subB)
                        4'd0, 4'd1, 4'd2, 4'd3: id = 7'h0c + {3'b0, subB[1:0], fnB};
                        4'd4: begin                         // High-register add
                            case (fnB)
                                2'd1: id = 7'h1c;
                                2'd2: id = 7'h1d;
                                2'd3: id = 7'h1e;
                                default: id = 7'h0c;
                            endcase
                            regB[`REG_W-1] = fnB[0];
                            regD[`REG_W-1] = fnB[1];
                            regA[`REG_W-1] = fnB[1];
                        end
                        4'd5: begin                         // High-register compare
                            case (fnB)
                                2'd1: id = 7'h1f;
                                2'd2: id = 7'h20;
                                2'd3: id = 7'h21;
                                default: id = 7'h0c;
                            endcase
                            regB[`REG_W-1] = fnB[0];
                            regD[`REG_W-1] = fnB[1];
                            regA[`REG_W-1] = fnB[1];
                        end
                        4'd6: begin                         // High-register move
                            id             = 7'h22 + {5'b0, fnB};
                            regB[`REG_W-1] = fnB[0];
                            regD[`REG_W-1] = fnB[1];
                            regA[`REG_W-1] = fnB[1];
                        end
                        4'd7: begin                         // BX with condition
                            id   = 7'h26;
                            cond = imm8[7:4];
                            regA = `PC_REG;
                            regB = fldD;
                        end
                        default: id = 7'h7d;
                    endcase
                end
            end
            4'd5: begin                                     // Register-offset load/store
                id   = 7'h28 + {4'b0, instr.regFmt.op, instr.regFmt.funct1};
                regD = fldD;
                regA = fldA;
                regB = fldB;
            end
            4'd6, 4'd7, 4'd8: begin                         // Load/store with 5-bit offset
                id     = 7'h24 + {2'b0, opcode, instr.regFmt.op};
                regD   = fldD;
                regA   = fldA;
                offset = `OFFSET_W'(imm5);
            end
            4'd9: begin                                     // SP-relative load/store
                id     = instr.immFmt.op ? 7'h37 : 7'h36;
                regD   = immD;
                regA   = `SP_REG;
                offset = `OFFSET_W'(imm8);
            end
            4'd10: begin                                    // Address from PC or SP
                id     = instr.immFmt.op ? 7'h39 : 7'h38;
                regD   = immD;
                regA   = instr.immFmt.op ? `SP_REG : `PC_REG;
                offset = `OFFSET_W'(imm8);
            end
            4'd11: begin                                    // Format B misc group
                case (subB)
                    4'd0: begin
                        if (fnB == 2'd1) begin
                            id   = 7'h4c;
                            regA = imm8[3:0];
                        end else begin
                            id   = 7'h3a;
                            regD = imm8[3:0];
                        end
                    end
                    4'd1: begin                             // BL and BX are always taken
                        id   = imm8[7] ? 7'h50 : 7'h4f;
                        cond = 4'he;
                        regD = `LINK_REG;
                        regA = `PC_REG;
                        regB = imm8[3:0];
                    end
                    4'd2: begin
                        id   = 7'h3b + {5'b0, fnB};
                        regD = fldD;
                        regB = fldA;
                    end
                    4'd4, 4'd13: begin                      // Single and multiple push and pop
                        if (imm8[7]) begin
                            id     = (subB == 4'd4) ? 7'h4d : 7'h4e;
                            regA   = `SP_REG;
                            offset = `OFFSET_W'(imm8[6:0]);
                        end else begin
                            id   = (subB == 4'd4) ? 7'h43 : 7'h44;
                            regD = fldD;
                        end
                    end
                    4'd10: begin
                        id   = 7'h3f + {5'b0, fnB};
                        regD = fldD;
                        regA = fldD;
                        regB = fldA;
                    end
                    4'd14: begin                            // I/O and pause
                        case (fnB)
                            2'd0: id = 7'h45;
                            2'd1: id = 7'h46;
                            2'd2: id = 7'h47;
                            default: id = 7'h7a;
                        endcase
                        if (fnB != 2'd1) begin
                            regD = fldD;
                        end
                    end
                    default: id = 7'h7a;
                endcase
            end
            4'd12: begin                                    // Software interrupt
                id     = 7'h48;
                offset = `OFFSET_W'(imm8);
            end
            4'd13: begin                                    // Conditional branch
                id     = 7'h49;
                cond   = subB;
                regA   = `PC_REG;
                offset = `OFFSET_W'(imm8);
            end
            4'd14: id = instr.immFmt.op ? 7'h4b : 7'h4a;   // HLT or NOP
            4'd15: id = (instr == {`INSTR_W{1'b1}}) ? 7'h64 : 7'h7f;
        endcase
    end

    assign dec.id         = id;
    assign dec.regD       = regD;
    assign dec.regA       = regA;
    assign dec.regB       = regB;
    assign dec.offset     = offset;
    assign dec.branchCond = cond;

endmodule

// ==== src/registerFile.sv ====
`include "cpu_defs.svh"

module registerFile (
    input  logic               clk,
    input  logic               rstN,
    input  logic               wrEn,
    input  logic [`REG_W-1:0]  wrAddr,
    input  logic [`DATA_W-1:0] wrData,
    regReadIf.file             rd
);

    // R12 link, R14 stack pointer, R15 program counter
    logic [`DATA_W-1:0] regs [1 << `REG_W];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '{default: '0};                     // Whole file cleared
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Reads see contents before the current edge
    assign rd.dataA = regs[rd.addrA];
    assign rd.dataB = regs[rd.addrB];

    // Writeback control must be clean once running
    assert property (@(posedge clk) disable iff (!rstN) !$isunknown(wrEn));

    assert property (@(posedge clk) disable iff (!rstN)
        wrEn |-> !$isunknown(wrAddr));

endmodule
